// File: logic/tetris_pkg.sv
package tetris_pkg;

    localparam int ROWS = 22;               // Row 0 is the top
    localparam int COLS = 10;

    typedef logic [ROWS*COLS-1:0] grid_t;   // Cell (r,c) at bit r*COLS+c
    typedef logic [COLS-1:0]      row_t;    // Bit c is column c
    typedef logic [2:0]           shape_t;
    typedef logic [1:0]           move_t;
    typedef logic [15:0]          count_t;

    // Shape codes
    localparam shape_t SHAPE_I = 3'd0;
    localparam shape_t SHAPE_O = 3'd1;
    localparam shape_t SHAPE_T = 3'd2;
    localparam shape_t SHAPE_S = 3'd3;
    localparam shape_t SHAPE_Z = 3'd4;
    localparam shape_t SHAPE_J = 3'd5;
    localparam shape_t SHAPE_L = 3'd6;

    // Sideways request, code 3 acts as none
    localparam move_t MOVE_NONE  = 2'd0;
    localparam move_t MOVE_LEFT  = 2'd1;
    localparam move_t MOVE_RIGHT = 2'd2;

    typedef enum logic [2:0] {
        SPAWN    = 3'd0,
        FALLING  = 3'd1,
        LANDED   = 3'd2,
        CLEARING = 3'd3,
        OVER     = 3'd4
    } game_state_t;

    // Spawn grid of one shape, rows 0 and 1, left edge at column 3
    function automatic grid_t piece_grid(input shape_t shape);
        row_t  top;
        row_t  bot;
        grid_t g;
        case (shape)
            SHAPE_I: begin top = 10'b0001111000; bot = 10'b0000000000; end
            SHAPE_O: begin top = 10'b0000011000; bot = 10'b0000011000; end
            SHAPE_T: begin top = 10'b0000111000; bot = 10'b0000010000; end
            SHAPE_S: begin top = 10'b0000110000; bot = 10'b0000011000; end
            SHAPE_Z: begin top = 10'b0000011000; bot = 10'b0000110000; end
            SHAPE_J: begin top = 10'b0000001000; bot = 10'b0000111000; end
            SHAPE_L: begin top = 10'b0000100000; bot = 10'b0000111000; end
            default: begin top = '0; bot = '0; end  // Unused code, empty piece
        endcase
        g = '0;
        g[COLS-1:0]      = top;
        g[2*COLS-1:COLS] = bot;
        return g;
    endfunction

endpackage

// File: logic/piece_gen.sv
`timescale 1ns/1ps

module piece_gen #(
    parameter int SEQ_LEN = 7               // Shapes in the cycle, 1 to 7
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              spawn_enable, // High for the SPAWN cycle
    output tetris_pkg::grid_t spawn_grid    // Current shape at spawn position
);

    tetris_pkg::shape_t shape_idx;          // Index of the next piece
    logic               at_last;            // Index is at end of cycle

    // Wrap point of the sequence
    assign at_last = (shape_idx == tetris_pkg::shape_t'(SEQ_LEN - 1));

    // Sequence counter
    // Steps once per spawn, so the next SPAWN sees the following shape
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            shape_idx <= '0;                // First piece is I
        end else if (spawn_enable) begin
            if (at_last)
                shape_idx <= '0;            // Back to the first shape
            else
                shape_idx <= shape_idx + 1'b1;
        end
    end

    // Table lookup, valid every cycle
    assign spawn_grid = tetris_pkg::piece_grid(shape_idx);

endmodule

// File: logic/piece_drop.sv
`timescale 1ns/1ps

module piece_drop (
    input  logic               clk,
    input  logic               reset,
    input  logic               drop_tick,   // One-cycle game pace
    input  tetris_pkg::move_t  move,        // Sampled on a tick only
    input  logic               load,        // New piece from the FSM
    input  tetris_pkg::grid_t  load_grid,
    input  tetris_pkg::grid_t  stored,      // Permanent cells, for collisions
    output tetris_pkg::grid_t  piece,       // Falling piece
    output logic               landed       // Held until the next load
);

    localparam int ROWS = tetris_pkg::ROWS;
    localparam int COLS = tetris_pkg::COLS;

    logic [ROWS-1:0]   at_left;             // Per row, cell in column 0
    logic [ROWS-1:0]   at_right;            // Per row, cell in column 9
    tetris_pkg::grid_t shifted;             // Sideways candidate
    tetris_pkg::grid_t moved;               // Piece after the legal move
    tetris_pkg::grid_t fallen;              // One row lower
    logic              shift_ok;
    logic              fall_ok;

    // Edge columns of the piece, a shift past them would wrap rows
    for (genvar r = 0; r < ROWS; r++) begin : g_edge
        assign at_left[r]  = piece[r*COLS];
        assign at_right[r] = piece[r*COLS + COLS - 1];
    end

    always_comb begin
        shifted  = piece;
        shift_ok = 1'b0;
        case (move)
            tetris_pkg::MOVE_LEFT: begin
                shifted  = piece >> 1;      // Lower column index
                shift_ok = ~|at_left;
            end
            tetris_pkg::MOVE_RIGHT: begin
                shifted  = piece << 1;
                shift_ok = ~|at_right;
            end
            tetris_pkg::MOVE_NONE: begin
                shifted  = piece;
                shift_ok = 1'b0;
            end
            default: begin                  // Spare code, no move
                shifted  = piece;
                shift_ok = 1'b0;
            end
        endcase
        // Shifted piece must stay off stored cells too
        shift_ok = shift_ok && ~|(shifted & stored);
        moved    = shift_ok ? shifted : piece;

        // Fall check against the floor and the stack
        fallen  = moved << COLS;
        fall_ok = ~|moved[ROWS*COLS-1 -: COLS] && ~|(fallen & stored);
    end

    // Move first, then fall, all on one tick
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            piece  <= '0;
            landed <= 1'b0;
        end else if (load) begin
            piece  <= load_grid;            // Fresh piece from spawn
            landed <= 1'b0;
        end else if (drop_tick && !landed) begin
            if (fall_ok) begin
                piece <= fallen;
            end else begin
                piece  <= moved;            // Keep the sideways step
                landed <= 1'b1;             // Blocked below
            end
        end
    end

endmodule

// File: logic/playfield_store.sv
`timescale 1ns/1ps

module playfield_store (
    input  logic               clk,
    input  logic               reset,
    input  logic               merge_en,    // LANDED pulse
    input  tetris_pkg::grid_t  piece,       // Landed piece to merge
    output tetris_pkg::grid_t  stored,      // Permanent grid
    output logic               full_row,    // Some row still full
    output tetris_pkg::count_t lines_cleared
);

    localparam int ROWS = tetris_pkg::ROWS;
    localparam int COLS = tetris_pkg::COLS;
    localparam int RW   = $clog2(ROWS);

    logic [ROWS-1:0]   row_full;            // Per-row full flags
    logic [RW-1:0]     low_row;             // Lowest full row, largest index
    tetris_pkg::grid_t cleared;             // Grid with low_row removed
    tetris_pkg::row_t  above;               // Row shifted into place

    // Full detection, last match wins so the lowest row is picked
    always_comb begin
        low_row = '0;
        for (int r = 0; r < ROWS; r++) begin
            row_full[r] = &stored[r*COLS +: COLS];
            if (row_full[r])
                low_row = RW'(r);
        end
    end

    assign full_row = |row_full;

    // Remove low_row, rows above move down one
    always_comb begin
        cleared = '0;                       // Row 0 refills empty
        above   = '0;
        for (int r = 1; r < ROWS; r++) begin
            if (r > low_row) begin
                cleared[r*COLS +: COLS] = stored[r*COLS +: COLS];   // Below, untouched
            end else begin
                above                   = stored[(r-1)*COLS +: COLS];
                cleared[r*COLS +: COLS] = above;
            end
        end
    end

    // Merge has priority, one row cleared per cycle otherwise
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stored        <= '0;
            lines_cleared <= '0;
        end else if (merge_en) begin
            stored <= stored | piece;
        end else if (full_row) begin
            stored        <= cleared;
            lines_cleared <= lines_cleared + 1'b1;
        end
    end

endmodule

// File: logic/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
    input  logic              clk,
    input  logic              reset,
    input  tetris_pkg::grid_t spawn_grid,   // From piece_gen
    input  tetris_pkg::grid_t piece,        // Falling piece
    input  logic              landed,
    input  tetris_pkg::grid_t stored,
    input  logic              full_row,
    output logic              spawn_enable, // Advances the shape index
    output logic              load,         // Capture pulse to piece_drop
    output tetris_pkg::grid_t load_grid,
    output logic              merge_en,
    output tetris_pkg::grid_t display,
    output logic              finish
);

    tetris_pkg::game_state_t state;
    tetris_pkg::game_state_t next_state;
    logic                    overlap;       // New piece hits the stack

    // Spawn check against the stored grid
    assign overlap = |(spawn_grid & stored);

    // State register
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            state <= tetris_pkg::SPAWN;
        else
            state <= next_state;
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            tetris_pkg::SPAWN: begin
                // Single cycle, top out or start the fall
                if (overlap)
                    next_state = tetris_pkg::OVER;
                else
                    next_state = tetris_pkg::FALLING;
            end
            tetris_pkg::FALLING: begin
                if (landed)
                    next_state = tetris_pkg::LANDED;
            end
            tetris_pkg::LANDED: begin
                next_state = tetris_pkg::CLEARING;  // Merge lands this edge
            end
            tetris_pkg::CLEARING: begin
                // One removed row per cycle in the store
                if (!full_row)
                    next_state = tetris_pkg::SPAWN;
            end
            tetris_pkg::OVER: begin
                next_state = tetris_pkg::OVER;      // Until reset
            end
            default: begin
                next_state = tetris_pkg::SPAWN;
            end
        endcase
    end

    // Control outputs
    assign spawn_enable = (state == tetris_pkg::SPAWN);
    assign load         = (state == tetris_pkg::SPAWN) && !overlap;
    assign load_grid    = spawn_grid;       // Taken by piece_drop on load
    assign merge_en     = (state == tetris_pkg::LANDED);
    assign finish       = (state == tetris_pkg::OVER);

    // Display mux
    always_comb begin
        case (state)
            tetris_pkg::SPAWN:   display = stored | spawn_grid;
            tetris_pkg::FALLING: display = stored | piece;
            default:             display = stored;  // Piece merged or game over
        endcase
    end

endmodule

// File: logic/tetris_top.sv
`timescale 1ns/1ps

module tetris_top #(
    parameter int SEQ_LEN = 7               // Shape cycle length
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               drop_tick,   // Game pace pulse
    input  tetris_pkg::move_t  move,
    output tetris_pkg::grid_t  display,
    output logic               spawn_enable,
    output tetris_pkg::count_t lines_cleared,
    output logic               finish
);

    tetris_pkg::grid_t spawn_grid;          // Gen to FSM
    tetris_pkg::grid_t load_grid;           // FSM to drop
    tetris_pkg::grid_t piece;               // Drop to FSM and store
    tetris_pkg::grid_t stored;              // Store to drop and FSM
    logic              load;
    logic              landed;
    logic              merge_en;
    logic              full_row;

    piece_gen #(
        .SEQ_LEN (SEQ_LEN)
    ) u_piece_gen (
        .clk          (clk),
        .reset        (reset),
        .spawn_enable (spawn_enable),
        .spawn_grid   (spawn_grid)
    );

    piece_drop u_piece_drop (
        .clk       (clk),
        .reset     (reset),
        .drop_tick (drop_tick),
        .move      (move),
        .load      (load),
        .load_grid (load_grid),
        .stored    (stored),
        .piece     (piece),
        .landed    (landed)
    );

    playfield_store u_playfield_store (
        .clk           (clk),
        .reset         (reset),
        .merge_en      (merge_en),
        .piece         (piece),
        .stored        (stored),
        .full_row      (full_row),
        .lines_cleared (lines_cleared)
    );

    game_fsm u_game_fsm (
        .clk          (clk),
        .reset        (reset),
        .spawn_grid   (spawn_grid),
        .piece        (piece),
        .landed       (landed),
        .stored       (stored),
        .full_row     (full_row),
        .spawn_enable (spawn_enable),
        .load         (load),
        .load_grid    (load_grid),
        .merge_en     (merge_en),
        .display      (display),
        .finish       (finish)
    );

endmodule

// File: bench/tb_tetris.sv
`timescale 1ns/1ps

module tb_tetris;

    localparam int SEQ_LEN    = 7;
    localparam int NUM_TICKS  = 800;                // Tick budget for the whole game
    localparam int TICK_GAP   = 4;                  // Cycles per tick
    localparam int MAX_CYCLES = TICK_GAP * NUM_TICKS + 200;
    localparam int AFTER_OVER = 20;                 // Ticks sent while finish is high
    localparam int ROWS       = tetris_pkg::ROWS;
    localparam int COLS       = tetris_pkg::COLS;

    logic               clk;
    logic               reset;
    logic               drop_tick;
    tetris_pkg::move_t  move;
    tetris_pkg::grid_t  display;
    logic               spawn_enable;
    tetris_pkg::count_t lines_cleared;
    logic               finish;

    // Reference model
    tetris_pkg::game_state_t m_state;
    tetris_pkg::grid_t       m_stored;
    tetris_pkg::grid_t       m_piece;
    logic                    m_landed;
    int                      m_idx;                 // Shape of the next spawn
    int                      m_lines;
    int                      m_loads;               // Pieces loaded so far
    int                      m_ticks;               // Ticks applied to current piece

    logic [31:0] lcg_state = 32'd56067;
    int          cycles = 0;
    int          tick_n;
    int          extra;
    string       fail_reason;

    // Opening moves fill row 21 with two I pieces and an O
    // Pieces in between pile up on the left
    tetris_pkg::move_t plan_dir [8] = '{tetris_pkg::MOVE_LEFT, tetris_pkg::MOVE_RIGHT,
        tetris_pkg::MOVE_LEFT, tetris_pkg::MOVE_LEFT, tetris_pkg::MOVE_LEFT,
        tetris_pkg::MOVE_LEFT, tetris_pkg::MOVE_LEFT, tetris_pkg::MOVE_RIGHT};
    int plan_steps [8] = '{3, 1, 3, 3, 3, 3, 3, 3};

    tetris_top #(.SEQ_LEN(SEQ_LEN)) u_tetris_top (
        .clk           (clk),
        .reset         (reset),
        .drop_tick     (drop_tick),
        .move          (move),
        .display       (display),
        .spawn_enable  (spawn_enable),
        .lines_cleared (lines_cleared),
        .finish        (finish)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input tetris_pkg::grid_t got,
                               input tetris_pkg::grid_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Offset every cell by dr rows and dc columns
    // ok goes low when a cell leaves the well
    function automatic tetris_pkg::grid_t move_cells(input tetris_pkg::grid_t g, input int dr,
                                                     input int dc, output logic ok);
        tetris_pkg::grid_t res;
        res = '0;
        ok  = 1'b1;
        for (int r = 0; r < ROWS; r++)
            for (int c = 0; c < COLS; c++)
                if (g[r*COLS + c]) begin
                    if (r + dr >= ROWS || c + dc < 0 || c + dc >= COLS)
                        ok = 1'b0;                  // Past floor or wall
                    else
                        res[(r+dr)*COLS + c + dc] = 1'b1;
                end
        return res;
    endfunction

    function automatic tetris_pkg::grid_t expected_display();
        case (m_state)
            tetris_pkg::SPAWN:
                return m_stored | tetris_pkg::piece_grid(tetris_pkg::shape_t'(m_idx));
            tetris_pkg::FALLING: return m_stored | m_piece;
            default:             return m_stored;
        endcase
    endfunction

    task automatic reset_model();
        m_state  = tetris_pkg::SPAWN;
        m_stored = '0;
        m_piece  = '0;
        m_landed = 1'b0;
        m_idx    = 0;
        m_lines  = 0;
        m_loads  = 0;
        m_ticks  = 0;
    endtask

    // One clock of game rules
    task automatic step_model();
        tetris_pkg::grid_t cand;
        logic              ok;
        int                row;
        case (m_state)
            tetris_pkg::SPAWN: begin
                cand  = tetris_pkg::piece_grid(tetris_pkg::shape_t'(m_idx));
                m_idx = (m_idx + 1) % SEQ_LEN;
                if (|(cand & m_stored)) begin
                    m_state = tetris_pkg::OVER;     // Topped out
                end else begin
                    m_piece  = cand;
                    m_landed = 1'b0;
                    m_ticks  = 0;
                    m_loads++;
                    m_state  = tetris_pkg::FALLING;
                end
            end
            tetris_pkg::FALLING: begin
                if (m_landed) begin
                    m_state = tetris_pkg::LANDED;
                end else if (drop_tick) begin
                    if (move == tetris_pkg::MOVE_LEFT || move == tetris_pkg::MOVE_RIGHT) begin
                        cand = move_cells(m_piece, 0,
                                          (move == tetris_pkg::MOVE_LEFT) ? -1 : 1, ok);
                        if (ok && !(|(cand & m_stored)))
                            m_piece = cand;
                    end
                    cand = move_cells(m_piece, 1, 0, ok);   // Then one row down
                    if (ok && !(|(cand & m_stored)))
                        m_piece = cand;
                    else
                        m_landed = 1'b1;
                    m_ticks++;
                end
            end
            tetris_pkg::LANDED: begin
                m_stored = m_stored | m_piece;
                m_state  = tetris_pkg::CLEARING;
            end
            tetris_pkg::CLEARING: begin
                row = -1;
                for (int r = 0; r < ROWS; r++)
                    if (&m_stored[r*COLS +: COLS])
                        row = r;                    // Lowest full row wins
                if (row < 0) begin
                    m_state = tetris_pkg::SPAWN;
                end else begin
                    for (int r = row; r > 0; r--)
                        m_stored[r*COLS +: COLS] = m_stored[(r-1)*COLS +: COLS];
                    m_stored[0 +: COLS] = '0;
                    m_lines++;
                end
            end
            default: begin
            end                                     // OVER holds
        endcase
    endtask

    // Scripted moves for the opening pieces
    // LCG choice for all later pieces
    function automatic tetris_pkg::move_t choose_move();
        int          k;
        logic [31:0] r;
        k = m_loads - 1;
        if (k >= 0 && k < 8) begin
            if (m_ticks < plan_steps[k])
                return plan_dir[k];
            return tetris_pkg::MOVE_NONE;
        end
        r = lcg_next();
        case (r[18:16])
            3'd0:    return tetris_pkg::MOVE_LEFT;
            3'd1:    return tetris_pkg::MOVE_RIGHT;
            3'd2:    return tetris_pkg::move_t'(2'd3);  // Spare code that acts as none
            default: return tetris_pkg::MOVE_NONE;
        endcase
    endfunction

    always @(posedge clk, posedge reset) begin
        if (reset)
            reset_model();
        else
            step_model();
    end

    // Outputs settle by the falling edge
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            check_value("display", display, expected_display());
            check_value("lines_cleared", lines_cleared, m_lines);
            check_value("finish", finish, m_state == tetris_pkg::OVER);
            check_value("spawn_enable", spawn_enable, m_state == tetris_pkg::SPAWN);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish in time", cycles);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        reset       = 1'b1;
        drop_tick   = 1'b0;
        move        = tetris_pkg::MOVE_NONE;
        extra       = 0;
        tick_n      = 0;
        fail_reason = "";
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        // First view shows the I piece in row 0 columns 3 to 6
        check_value("display", display, tetris_pkg::grid_t'(10'b0001111000));
        check_value("lines_cleared", lines_cleared, 0);
        check_value("finish", finish, 0);
        while (tick_n < NUM_TICKS && extra < AFTER_OVER) begin
            @(posedge clk);
            #2;
            if (m_state == tetris_pkg::OVER)
                extra++;
            drop_tick = 1'b1;
            move      = choose_move();
            @(posedge clk);
            #2;
            drop_tick = 1'b0;
            repeat (TICK_GAP - 2) @(posedge clk);
            tick_n++;
        end
        @(negedge clk);
        #1;
        if (m_state != tetris_pkg::OVER)
            fail_reason = "game over was never reached within the planned ticks";
        else if (m_lines == 0)
            fail_reason = "no full row was cleared during the run";
        if (fail_reason != "") begin
            $display("%s", fail_reason);
            $display("STATUS: FAIL");
            $fatal(1, "run incomplete");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: sim.f
logic/tetris_pkg.sv
logic/piece_gen.sv
logic/piece_drop.sv
logic/playfield_store.sv
logic/game_fsm.sv
logic/tetris_top.sv
bench/tb_tetris.sv
